// ==== logic/isa_pkg.sv ====
package isa_pkg;

    // width of one data bus word
    localparam int WORD_W = 16;

    // instruction kind, upper byte of an opcode word
    typedef enum logic [7:0] {
        NOP    = 8'h00,
        ALU_RR = 8'h01,
        ALU_RI = 8'h02,
        JMP    = 8'h03,
        MOV_AR = 8'h04,
        MOV_RA = 8'h05,
        PUSH   = 8'h06,
        POP    = 8'h07
    } instr_kind_e;

    // alu operation, lower byte of an opcode word
    localparam logic [7:0] ALU_ADD  = 8'h01;
    localparam logic [7:0] ALU_SUB  = 8'h02;
    localparam logic [7:0] ALU_AND  = 8'h03;
    localparam logic [7:0] ALU_OR   = 8'h04;
    localparam logic [7:0] ALU_NOT  = 8'h05;
    localparam logic [7:0] ALU_XOR  = 8'h06;
    // MOV_RR under ALU_RR, LOAD under ALU_RI
    localparam logic [7:0] ALU_MOVE = 8'hff;

    typedef struct packed {
        instr_kind_e kind;
        logic [7:0]  alu_op;
    } opcode_t;

    // register argument, only the low nibble selects
    typedef struct packed {
        logic [11:0] unused;
        logic [3:0]  reg_sel;
    } reg_arg_t;

    // one bus word, seen as opcode, register argument or plain value
    typedef union packed {
        opcode_t           op;
        reg_arg_t          reg_arg;
        logic [WORD_W-1:0] raw;
    } bus_word_u;

    // complete instruction handed from the sequencer to the encoder
    typedef struct packed {
        logic      valid;
        opcode_t   op;
        bus_word_u arg_a;
        bus_word_u arg_b;
    } issue_t;

endpackage

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    // bus i/o; lock_out must be set whenever write is
    typedef struct packed {
        logic write;
        logic lock_out;
    } io_ctrl_t;

    // program counter
    typedef struct packed {
        logic lock;
        logic out_en;
        logic set;
    } pc_ctrl_t;

    // decoder bus drivers
    typedef struct packed {
        logic lock;
        logic addr_en;
        logic data_en;
        logic data_out;
    } dc_ctrl_t;

    // alu and register file
    typedef struct packed {
        logic [7:0] op;
        logic [3:0] sel_b;
        logic [3:0] sel_a;
        logic       dc_en;
        logic       io_en;
        logic       reg_out;
    } alu_ctrl_t;

    // register select codes, 1 to 6 are registers A to F
    localparam logic [3:0] SEL_NONE = 4'h0;
    localparam logic [3:0] SEL_IMM  = 4'h8;

    typedef struct packed {
        io_ctrl_t                    io;
        pc_ctrl_t                    pc;
        dc_ctrl_t                    dc;
        alu_ctrl_t                   alu;
        logic [isa_pkg::WORD_W-1:0]  data_alu;
        logic [isa_pkg::WORD_W-1:0]  addr;
    } ctrl_bundle_t;

    // fetching: pc drives the address, data bus read in
    localparam ctrl_bundle_t CTRL_IDLE = '{
        io:       '{write: 1'b0, lock_out: 1'b0},
        pc:       '{lock: 1'b0, out_en: 1'b1, set: 1'b0},
        dc:       '{lock: 1'b0, addr_en: 1'b0, data_en: 1'b1, data_out: 1'b0},
        alu:      '{
            op:      8'h00,
            sel_b:   SEL_NONE,
            sel_a:   SEL_NONE,
            dc_en:   1'b0,
            io_en:   1'b0,
            reg_out: 1'b0
        },
        data_alu: '0,
        addr:     '0
    };

endpackage

// ==== logic/word_capture.sv ====
`timescale 1ns/1ps

module word_capture (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic [isa_pkg::WORD_W-1:0]  i_data,
    input  logic                        i_lock,
    output isa_pkg::bus_word_u          o_word,
    output logic                        o_word_valid
);

    isa_pkg::bus_word_u word_q;
    logic               valid_q;

    // word held while the bus is locked
    always_ff @(posedge clk) begin
        if (!i_lock) begin
            word_q.raw <= i_data;
        end
    end

    // a held word is not new, so it is never consumed twice
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= !i_lock;
        end
    end

    assign o_word       = word_q;
    assign o_word_valid = valid_q;

    // locked edge never hands a word downstream
    a_lock_stalls: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_lock |=> !o_word_valid
    );

endmodule

// ==== logic/instr_sequencer.sv ====
`timescale 1ns/1ps

module instr_sequencer (
    input  logic               clk,
    input  logic               n_rst,
    input  isa_pkg::bus_word_u i_word,
    input  logic               i_word_valid,
    input  logic               i_interrupt,
    output isa_pkg::issue_t    o_issue
);

    typedef enum logic [1:0] {
        FETCH,
        ARG_A,
        ARG_B
    } state_e;

    state_e             state_q;
    state_e             state_d;
    isa_pkg::opcode_t   op_q;
    isa_pkg::bus_word_u arg_a_q;
    logic               done;

    // argument words following the opcode
    function automatic logic [1:0] arg_count(input isa_pkg::instr_kind_e kind);
        logic [1:0] n;
        case (kind)
            isa_pkg::ALU_RR,
            isa_pkg::ALU_RI,
            isa_pkg::MOV_AR,
            isa_pkg::MOV_RA: n = 2'd2;
            isa_pkg::JMP,
            isa_pkg::PUSH,
            isa_pkg::POP:    n = 2'd1;
            // nop and unknown kinds
            default:         n = 2'd0;
        endcase
        return n;
    endfunction

    always_comb begin
        state_d = state_q;
        done    = 1'b0;
        if (i_word_valid) begin
            case (state_q)
                FETCH: begin
                    if (arg_count(i_word.op.kind) == 2'd0) begin
                        done = 1'b1;
                    end else begin
                        state_d = ARG_A;
                    end
                end
                ARG_A: begin
                    if (arg_count(op_q.kind) == 2'd1) begin
                        done    = 1'b1;
                        state_d = FETCH;
                    end else begin
                        state_d = ARG_B;
                    end
                end
                ARG_B: begin
                    done    = 1'b1;
                    state_d = FETCH;
                end
                default: state_d = FETCH;
            endcase
        end
        // interrupt drops the partly fetched instruction and this word
        if (i_interrupt) begin
            done    = 1'b0;
            state_d = FETCH;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_word_valid && state_q == FETCH) begin
            op_q <= i_word.op;
        end
        if (i_word_valid && state_q == ARG_A) begin
            arg_a_q <= i_word;
        end
    end

    // last word goes straight out as arg_b, no register for it
    always_comb begin
        o_issue.valid = done;
        o_issue.op    = (state_q == FETCH) ? i_word.op : op_q;
        o_issue.arg_a = (state_q == ARG_B) ? arg_a_q : i_word;
        o_issue.arg_b = i_word;
    end

    // two-argument instruction completes only on its second argument
    a_two_arg_from_arg_b: assert property (
        @(posedge clk) disable iff (!n_rst)
        (o_issue.valid && arg_count(o_issue.op.kind) == 2'd2) |-> state_q == ARG_B
    );

    a_interrupt_to_fetch: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_interrupt |=> state_q == FETCH
    );

endmodule

// ==== logic/ctrl_encoder.sv ====
`timescale 1ns/1ps

module ctrl_encoder (
    input  logic                  clk,
    input  logic                  n_rst,
    input  isa_pkg::issue_t       i_issue,
    output ctrl_pkg::ctrl_bundle_t o_ctrl
);

    ctrl_pkg::ctrl_bundle_t enc;
    ctrl_pkg::ctrl_bundle_t ctrl_q;

    // per-kind table, anything not set keeps its idle value
    always_comb begin
        enc = ctrl_pkg::CTRL_IDLE;
        case (i_issue.op.kind)
            isa_pkg::ALU_RR: begin
                enc.alu.op    = i_issue.op.alu_op;
                enc.alu.sel_a = i_issue.arg_a.reg_arg.reg_sel;
                enc.alu.sel_b = i_issue.arg_b.reg_arg.reg_sel;
            end
            isa_pkg::ALU_RI: begin
                enc.alu.op    = i_issue.op.alu_op;
                enc.alu.sel_a = i_issue.arg_a.reg_arg.reg_sel;
                enc.alu.sel_b = ctrl_pkg::SEL_IMM;
                enc.alu.dc_en = 1'b1;
                // immediate rides on the alu data word
                enc.data_alu  = i_issue.arg_b.raw;
            end
            isa_pkg::JMP: begin
                enc.pc   = '{lock: 1'b0, out_en: 1'b0, set: 1'b1};
                enc.dc   = '{lock: 1'b0, addr_en: 1'b1, data_en: 1'b1, data_out: 1'b0};
                enc.addr = i_issue.arg_a.raw;
            end
            isa_pkg::MOV_AR: begin
                // memory at a into register b
                enc.pc        = '{lock: 1'b1, out_en: 1'b0, set: 1'b0};
                enc.dc        = '{lock: 1'b0, addr_en: 1'b1, data_en: 1'b0, data_out: 1'b0};
                enc.alu.op    = i_issue.op.alu_op;
                enc.alu.sel_a = i_issue.arg_b.reg_arg.reg_sel;
                enc.alu.dc_en = 1'b1;
                enc.addr      = i_issue.arg_a.raw;
            end
            isa_pkg::MOV_RA: begin
                // register a out to memory at b
                enc.io          = '{write: 1'b1, lock_out: 1'b1};
                enc.pc          = '{lock: 1'b1, out_en: 1'b0, set: 1'b0};
                enc.dc          = '{lock: 1'b0, addr_en: 1'b1, data_en: 1'b0, data_out: 1'b0};
                enc.alu.op      = i_issue.op.alu_op;
                enc.alu.sel_a   = i_issue.arg_a.reg_arg.reg_sel;
                enc.alu.dc_en   = 1'b1;
                enc.alu.reg_out = 1'b1;
                enc.addr        = i_issue.arg_b.raw;
            end
            isa_pkg::PUSH: begin
                enc.io          = '{write: 1'b1, lock_out: 1'b1};
                enc.pc          = '{lock: 1'b1, out_en: 1'b0, set: 1'b0};
                enc.dc          = '{lock: 1'b0, addr_en: 1'b0, data_en: 1'b1, data_out: 1'b0};
                enc.alu.sel_a   = i_issue.arg_a.reg_arg.reg_sel;
                enc.alu.dc_en   = 1'b1;
                enc.alu.reg_out = 1'b1;
            end
            isa_pkg::POP: begin
                enc.pc        = '{lock: 1'b1, out_en: 1'b0, set: 1'b0};
                enc.dc        = '{lock: 1'b0, addr_en: 1'b0, data_en: 1'b1, data_out: 1'b0};
                enc.alu.sel_a = i_issue.arg_a.reg_arg.reg_sel;
                enc.alu.dc_en = 1'b1;
            end
            // nop and unknown kinds
            default: enc = ctrl_pkg::CTRL_IDLE;
        endcase
    end

    // one cycle per issued instruction, idle otherwise
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ctrl_q <= ctrl_pkg::CTRL_IDLE;
        end else if (i_issue.valid) begin
            ctrl_q <= enc;
        end else begin
            ctrl_q <= ctrl_pkg::CTRL_IDLE;
        end
    end

    assign o_ctrl = ctrl_q;

    a_pc_lock_set: assert property (
        @(posedge clk) disable iff (!n_rst)
        !(o_ctrl.pc.lock && o_ctrl.pc.set)
    );

    a_write_locked: assert property (
        @(posedge clk) disable iff (!n_rst)
        o_ctrl.io.write |-> o_ctrl.io.lock_out
    );

endmodule

// ==== logic/instr_decoder_top.sv ====
`timescale 1ns/1ps

module instr_decoder_top (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic [isa_pkg::WORD_W-1:0]  i_data,
    input  logic                        i_lock,
    input  logic                        i_interrupt,
    output ctrl_pkg::ctrl_bundle_t      o_ctrl
);

    isa_pkg::bus_word_u word;
    logic               word_valid;
    isa_pkg::issue_t    issue;

    // bus intake with lock stall
    word_capture word_capture_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_data       (i_data),
        .i_lock       (i_lock),
        .o_word       (word),
        .o_word_valid (word_valid)
    );

    instr_sequencer instr_sequencer_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_word       (word),
        .i_word_valid (word_valid),
        .i_interrupt  (i_interrupt),
        .o_issue      (issue)
    );

    // registered control bundle
    ctrl_encoder ctrl_encoder_i (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_issue (issue),
        .o_ctrl  (o_ctrl)
    );

endmodule

// ==== tb/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one clock cycle of inputs and the o_ctrl expected after the next edge
typedef struct packed {
    logic [isa_pkg::WORD_W-1:0] data;
    logic                       lock;
    logic                       intr;
    ctrl_pkg::ctrl_bundle_t     exp;
} row_t;

row_t rows[$];

function automatic ctrl_pkg::ctrl_bundle_t alu_rr_bundle(input logic [7:0] op,
        input logic [3:0] sel_a, input logic [3:0] sel_b);
    ctrl_pkg::ctrl_bundle_t b;
    b = ctrl_pkg::CTRL_IDLE;
    b.alu.op = op;
    b.alu.sel_a = sel_a;
    b.alu.sel_b = sel_b;
    return b;
endfunction

function automatic ctrl_pkg::ctrl_bundle_t alu_ri_bundle(input logic [7:0] op,
        input logic [3:0] sel_a, input logic [15:0] imm);
    ctrl_pkg::ctrl_bundle_t b;
    b = ctrl_pkg::CTRL_IDLE;
    b.alu.op = op;
    b.alu.sel_a = sel_a;
    b.alu.sel_b = ctrl_pkg::SEL_IMM;
    b.alu.dc_en = 1'b1;
    b.data_alu = imm;
    return b;
endfunction

function automatic ctrl_pkg::ctrl_bundle_t jmp_bundle(input logic [15:0] addr);
    ctrl_pkg::ctrl_bundle_t b;
    b = ctrl_pkg::CTRL_IDLE;
    b.pc.out_en = 1'b0;
    b.pc.set = 1'b1;
    b.dc.addr_en = 1'b1;
    b.addr = addr;
    return b;
endfunction

// memory transfers lock the pc and take the address from an argument
function automatic ctrl_pkg::ctrl_bundle_t mov_bundle(input logic write, input logic [7:0] op,
        input logic [3:0] sel_a, input logic [15:0] addr);
    ctrl_pkg::ctrl_bundle_t b;
    b = ctrl_pkg::CTRL_IDLE;
    b.io.write = write;
    b.io.lock_out = write;
    b.pc.out_en = 1'b0;
    b.pc.lock = 1'b1;
    b.dc.addr_en = 1'b1;
    b.dc.data_en = 1'b0;
    b.alu.op = op;
    b.alu.sel_a = sel_a;
    b.alu.dc_en = 1'b1;
    b.alu.reg_out = write;
    b.addr = addr;
    return b;
endfunction

// push writes the register out and pop reads it back
function automatic ctrl_pkg::ctrl_bundle_t stack_bundle(input logic push,
        input logic [3:0] sel_a);
    ctrl_pkg::ctrl_bundle_t b;
    b = ctrl_pkg::CTRL_IDLE;
    b.io.write = push;
    b.io.lock_out = push;
    b.pc.out_en = 1'b0;
    b.pc.lock = 1'b1;
    b.alu.sel_a = sel_a;
    b.alu.dc_en = 1'b1;
    b.alu.reg_out = push;
    return b;
endfunction

task automatic add_row(input logic [15:0] data, input logic lock, input logic intr,
        input ctrl_pkg::ctrl_bundle_t exp);
    row_t r;
    r.data = data;
    r.lock = lock;
    r.intr = intr;
    r.exp = exp;
    rows.push_back(r);
endtask

task automatic load_rows();
    ctrl_pkg::ctrl_bundle_t idle;
    idle = ctrl_pkg::CTRL_IDLE;
    // bundle shows up in the row after the last argument
    add_row({isa_pkg::ALU_RR, isa_pkg::ALU_ADD}, 1'b0, 1'b0, idle);
    add_row(16'h0001, 1'b0, 1'b0, idle);
    add_row(16'h0002, 1'b0, 1'b0, idle);
    add_row({isa_pkg::ALU_RI, isa_pkg::ALU_MOVE}, 1'b0, 1'b0, alu_rr_bundle(8'h01, 4'h1, 4'h2));
    add_row(16'h0003, 1'b0, 1'b0, idle);
    add_row(16'h1234, 1'b0, 1'b0, idle);
    add_row({isa_pkg::JMP, 8'h5a}, 1'b0, 1'b0, alu_ri_bundle(8'hff, 4'h3, 16'h1234));
    add_row(16'h0abc, 1'b0, 1'b0, idle);
    add_row({isa_pkg::MOV_AR, isa_pkg::ALU_MOVE}, 1'b0, 1'b0, jmp_bundle(16'h0abc));
    add_row(16'h2040, 1'b0, 1'b0, idle);
    add_row(16'h0004, 1'b0, 1'b0, idle);
    add_row({isa_pkg::MOV_RA, isa_pkg::ALU_MOVE}, 1'b0, 1'b0,
            mov_bundle(1'b0, 8'hff, 4'h4, 16'h2040));
    add_row(16'h0005, 1'b0, 1'b0, idle);
    add_row(16'h3001, 1'b0, 1'b0, idle);
    add_row({isa_pkg::PUSH, 8'h33}, 1'b0, 1'b0, mov_bundle(1'b1, 8'hff, 4'h5, 16'h3001));
    add_row(16'h0006, 1'b0, 1'b0, idle);
    add_row({isa_pkg::POP, 8'h44}, 1'b0, 1'b0, stack_bundle(1'b1, 4'h6));
    add_row(16'h0002, 1'b0, 1'b0, idle);
    add_row({isa_pkg::NOP, 8'h00}, 1'b0, 1'b0, stack_bundle(1'b0, 4'h2));
    // unknown kind behaves as nop
    add_row(16'h3c55, 1'b0, 1'b0, idle);
    add_row({isa_pkg::ALU_RR, isa_pkg::ALU_SUB}, 1'b0, 1'b0, idle);
    add_row(16'h0004, 1'b0, 1'b0, idle);
    add_row(16'h0001, 1'b0, 1'b0, idle);
    add_row({isa_pkg::NOP, 8'h00}, 1'b0, 1'b0, alu_rr_bundle(8'h02, 4'h4, 4'h1));
    // three locked edges between the arguments
    add_row({isa_pkg::ALU_RR, isa_pkg::ALU_XOR}, 1'b0, 1'b0, idle);
    add_row(16'h0003, 1'b0, 1'b0, idle);
    add_row(16'hdead, 1'b1, 1'b0, idle);
    add_row(16'hbeef, 1'b1, 1'b0, idle);
    add_row(16'hface, 1'b1, 1'b0, idle);
    add_row(16'h0006, 1'b0, 1'b0, idle);
    add_row({isa_pkg::NOP, 8'h00}, 1'b0, 1'b0, alu_rr_bundle(8'h06, 4'h3, 4'h6));
    // interrupt drops mov_ra after its first argument
    add_row({isa_pkg::MOV_RA, isa_pkg::ALU_MOVE}, 1'b0, 1'b0, idle);
    add_row(16'h0001, 1'b0, 1'b0, idle);
    add_row({isa_pkg::PUSH, 8'h00}, 1'b0, 1'b1, idle);
    add_row(16'h0003, 1'b0, 1'b0, idle);
    add_row({isa_pkg::NOP, 8'h00}, 1'b0, 1'b0, stack_bundle(1'b1, 4'h3));
    add_row({isa_pkg::NOP, 8'h00}, 1'b0, 1'b0, idle);
    add_row({isa_pkg::NOP, 8'h00}, 1'b0, 1'b0, idle);
endtask

task automatic check_ctrl(input ctrl_pkg::ctrl_bundle_t got,
        input ctrl_pkg::ctrl_bundle_t exp, input string where);
    if (got !== exp) begin
        $display("ERR o_ctrl at %s: got %h expected %h", where, got, exp);
        $display("Simulation failed");
        $fatal(1, "o_ctrl mismatch");
    end
endtask

`endif

// ==== tb/tb_instr_decoder.sv ====
`timescale 1ns/1ps

module tb_instr_decoder;

    logic                        clk;
    logic                        n_rst;
    logic [isa_pkg::WORD_W-1:0]  i_data;
    logic                        i_lock;
    logic                        i_interrupt;
    ctrl_pkg::ctrl_bundle_t      o_ctrl;
    logic                        table_ready;

    `include "tb_vectors.svh"

    instr_decoder_top instr_decoder_top_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_data      (i_data),
        .i_lock      (i_lock),
        .i_interrupt (i_interrupt),
        .o_ctrl      (o_ctrl)
    );

    // 4 ns period
    always #2 clk = ~clk;

    initial begin
        int k;
        clk         = 1'b0;
        n_rst       = 1'b0;
        i_data      = '0;
        i_lock      = 1'b0;
        i_interrupt = 1'b0;
        table_ready = 1'b0;
        load_rows();
        table_ready = 1'b1;

        // output must sit idle while reset is held
        repeat (4) begin
            @(posedge clk);
            #1;
            check_ctrl(o_ctrl, ctrl_pkg::CTRL_IDLE, "reset");
        end
        n_rst = 1'b1;

        // inputs change 1 ns after each edge, o_ctrl checked 1 ns after the next
        for (k = 0; k < rows.size(); k++) begin
            i_data      = rows[k].data;
            i_lock      = rows[k].lock;
            i_interrupt = rows[k].intr;
            @(posedge clk);
            #1;
            check_ctrl(o_ctrl, rows[k].exp, $sformatf("row %0d", k));
        end

        $display("Simulation passed");
        $finish;
    end

    // watchdog, sized from the table length
    initial begin
        wait (table_ready);
        #((rows.size() + 10) * 4);
        $display("stimulus table did not finish in time");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

// ==== instr_decoder.f ====
+incdir+tb
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/word_capture.sv
logic/instr_sequencer.sv
logic/ctrl_encoder.sv
logic/instr_decoder_top.sv
tb/tb_instr_decoder.sv
